/* source/gfx_vga_pkg.sv */
package gfx_vga_pkg;

  // horizontal mode, in pixels
  localparam int H_VISIBLE     = 8;
  localparam int H_FRONT_PORCH = 2;
  localparam int H_SYNC_PULSE  = 2;
  localparam int H_BACK_PORCH  = 2;
  localparam int H_WHOLE_LINE  = 14;

  // vertical mode, in lines
  localparam int V_VISIBLE     = 4;
  localparam int V_FRONT_PORCH = 1;
  localparam int V_SYNC_PULSE  = 1;
  localparam int V_BACK_PORCH  = 1;
  localparam int V_WHOLE_FRAME = 7;

  // sync pulse windows, start inclusive and end exclusive
  localparam int H_SYNC_START = H_VISIBLE + H_FRONT_PORCH;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC_PULSE;
  localparam int V_SYNC_START = V_VISIBLE + V_FRONT_PORCH;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC_PULSE;

  // 4 bits per channel, red in the top nibble
  localparam int PIXEL_BITS = 12;
  localparam int COLOR_BITS = 4;

  // one spare bit so off-screen coordinates reach the writer and get clipped
  localparam int FB_X_BITS = $clog2(H_VISIBLE) + 1;
  localparam int FB_Y_BITS = $clog2(V_VISIBLE) + 1;

  localparam int FB_PIXELS    = H_VISIBLE * V_VISIBLE;
  localparam int FB_ADDR_BITS = $clog2(FB_PIXELS);

  localparam int H_CNT_BITS = $clog2(H_WHOLE_LINE);
  localparam int V_CNT_BITS = $clog2(V_WHOLE_FRAME);

  // clk cycles per emitted pixel
  localparam int PIXEL_DIV      = 2;
  localparam int PIXEL_DIV_BITS = $clog2(PIXEL_DIV);

  localparam int FIFO_DEPTH        = 16;
  localparam int FIFO_ADDR_BITS    = $clog2(FIFO_DEPTH);
  localparam int ALMOST_FULL_LEVEL = 8;

  typedef logic [FB_ADDR_BITS-1:0]   fb_addr_t;
  typedef logic [PIXEL_BITS-1:0]     pixel_color_t;
  typedef logic [H_CNT_BITS-1:0]     h_cnt_t;
  typedef logic [V_CNT_BITS-1:0]     v_cnt_t;
  typedef logic [FIFO_ADDR_BITS-1:0] fifo_ptr_t;
  typedef logic [FIFO_ADDR_BITS:0]   fifo_cnt_t;
  typedef logic [PIXEL_DIV_BITS-1:0] div_cnt_t;

  typedef struct packed {
    logic         we;
    fb_addr_t     addr;
    pixel_color_t color;
  } fb_write_t;

  // sync levels are active low
  typedef struct packed {
    fb_addr_t addr;
    logic     hsync;
    logic     vsync;
    logic     visible;
  } scan_beat_t;

  typedef struct packed {
    logic         hsync;
    logic         vsync;
    pixel_color_t color;
  } vga_pixel_t;

  typedef enum logic [0:0] {
    IDLE,
    CLEAR
  } writer_state_e;

endpackage

/* source/fb_writer.sv */
module fb_writer (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [gfx_vga_pkg::FB_X_BITS-1:0]   gfx_x,
  input  logic [gfx_vga_pkg::FB_Y_BITS-1:0]   gfx_y,
  input  logic [gfx_vga_pkg::PIXEL_BITS-1:0]  gfx_color,
  input  logic                                gfx_valid,
  input  logic                                gfx_clear,
  output logic                                gfx_ready,
  output gfx_vga_pkg::fb_write_t              fb_write
);

  gfx_vga_pkg::writer_state_e state;
  gfx_vga_pkg::fb_addr_t      clr_addr;
  gfx_vga_pkg::fb_addr_t      pix_addr;
  logic                       in_range;

  // the client is only served outside of a clear sweep
  assign gfx_ready = (state == gfx_vga_pkg::IDLE);

  // clip to the visible area
  assign in_range = (int'(gfx_x) < gfx_vga_pkg::H_VISIBLE) &&
                    (int'(gfx_y) < gfx_vga_pkg::V_VISIBLE);

  // raster address, row major
  assign pix_addr = gfx_vga_pkg::fb_addr_t'(int'(gfx_y) * gfx_vga_pkg::H_VISIBLE +
                                            int'(gfx_x));

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= gfx_vga_pkg::CLEAR;
      clr_addr    <= '0;
      fb_write.we <= 1'b0;
    end else begin
      case (state)
        gfx_vga_pkg::IDLE: begin
          // off-screen pixels are taken but never written
          fb_write.we    <= gfx_valid && in_range;
          fb_write.addr  <= pix_addr;
          fb_write.color <= gfx_color;
          if (gfx_clear) begin
            state    <= gfx_vga_pkg::CLEAR;
            clr_addr <= '0;
          end
        end
        gfx_vga_pkg::CLEAR: begin
          // one zero write per cycle across the whole buffer
          fb_write.we    <= 1'b1;
          fb_write.addr  <= clr_addr;
          fb_write.color <= '0;
          clr_addr       <= clr_addr + 1'b1;
          if (int'(clr_addr) == gfx_vga_pkg::FB_PIXELS - 1) begin
            state <= gfx_vga_pkg::IDLE;
          end
        end
        default: state <= gfx_vga_pkg::CLEAR;
      endcase
    end
  end

  // every write lands inside the buffer
  assert property (@(posedge clk) disable iff (rst)
    fb_write.we |-> int'(fb_write.addr) < gfx_vga_pkg::FB_PIXELS);

endmodule

/* source/fb_memory.sv */
module fb_memory (
  input  logic                                clk,
  input  gfx_vga_pkg::fb_write_t              fb_write,
  input  logic [gfx_vga_pkg::FB_ADDR_BITS-1:0] rd_addr,
  output logic [gfx_vga_pkg::PIXEL_BITS-1:0]  rd_color
);

  // one word per visible pixel
  gfx_vga_pkg::pixel_color_t mem [gfx_vga_pkg::FB_PIXELS];

  // write port, driven by the writer only
  always_ff @(posedge clk) begin
    if (fb_write.we) begin
      mem[fb_write.addr] <= fb_write.color;
    end
  end

  // registered read port for the scan side
  // a read that collides with a write sees the old word
  always_ff @(posedge clk) begin
    rd_color <= mem[rd_addr];
  end

endmodule

/* source/vga_timing.sv */
module vga_timing (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    vga_enable,
  input  logic                    fifo_almost_full,
  output gfx_vga_pkg::scan_beat_t beat,
  output logic                    beat_strobe,
  output logic                    gfx_vsync
);

  gfx_vga_pkg::h_cnt_t     x_cnt;
  gfx_vga_pkg::v_cnt_t     y_cnt;
  gfx_vga_pkg::scan_beat_t next_beat;
  logic                    advance;
  logic                    last_x;
  logic                    last_y;

  // hold position while paused or while the output FIFO is backing up
  assign advance = vga_enable && !fifo_almost_full;

  assign last_x = (int'(x_cnt) == gfx_vga_pkg::H_WHOLE_LINE - 1);
  assign last_y = (int'(y_cnt) == gfx_vga_pkg::V_WHOLE_FRAME - 1);

  // decode the current raster position
  always_comb begin
    next_beat.visible = (int'(x_cnt) < gfx_vga_pkg::H_VISIBLE) &&
                        (int'(y_cnt) < gfx_vga_pkg::V_VISIBLE);
    next_beat.hsync   = !((int'(x_cnt) >= gfx_vga_pkg::H_SYNC_START) &&
                          (int'(x_cnt) <  gfx_vga_pkg::H_SYNC_END));
    next_beat.vsync   = !((int'(y_cnt) >= gfx_vga_pkg::V_SYNC_START) &&
                          (int'(y_cnt) <  gfx_vga_pkg::V_SYNC_END));
    if (next_beat.visible) begin
      next_beat.addr = gfx_vga_pkg::fb_addr_t'(int'(y_cnt) * gfx_vga_pkg::H_VISIBLE +
                                               int'(x_cnt));
    end else begin
      next_beat.addr = '0;
    end
  end

  // raster counters
  always_ff @(posedge clk) begin
    if (rst) begin
      x_cnt <= '0;
      y_cnt <= '0;
    end else if (advance) begin
      if (last_x) begin
        x_cnt <= '0;
        y_cnt <= last_y ? '0 : y_cnt + 1'b1;
      end else begin
        x_cnt <= x_cnt + 1'b1;
      end
    end
  end

  // beat register, idles with syncs inactive
  always_ff @(posedge clk) begin
    if (rst) begin
      beat.addr    <= '0;
      beat.hsync   <= 1'b1;
      beat.vsync   <= 1'b1;
      beat.visible <= 1'b0;
      beat_strobe  <= 1'b0;
    end else begin
      beat_strobe <= advance;
      if (advance) begin
        beat <= next_beat;
      end
    end
  end

  // client sees the scan-side vsync, as the panel will a little later
  assign gfx_vsync = beat.vsync;

  assert property (@(posedge clk) disable iff (rst)
    int'(x_cnt) < gfx_vga_pkg::H_WHOLE_LINE);

  assert property (@(posedge clk) disable iff (rst)
    int'(y_cnt) < gfx_vga_pkg::V_WHOLE_FRAME);

endmodule

/* source/pixel_fetch.sv */
module pixel_fetch (
  input  logic                                 clk,
  input  logic                                 rst,
  input  gfx_vga_pkg::scan_beat_t              beat,
  input  logic                                 beat_strobe,
  output logic [gfx_vga_pkg::FB_ADDR_BITS-1:0] rd_addr,
  input  logic [gfx_vga_pkg::PIXEL_BITS-1:0]   rd_color,
  output gfx_vga_pkg::vga_pixel_t              pixel,
  output logic                                 push
);

  logic hsync_q;
  logic vsync_q;
  logic visible_q;

  // memory read issued in the beat's own cycle
  assign rd_addr = beat.addr;

  // one stage to match the registered read port
  // a new beat can enter while the previous one is here, so two are in flight
  always_ff @(posedge clk) begin
    if (rst) begin
      push      <= 1'b0;
      hsync_q   <= 1'b1;
      vsync_q   <= 1'b1;
      visible_q <= 1'b0;
    end else begin
      push <= beat_strobe;
      if (beat_strobe) begin
        hsync_q   <= beat.hsync;
        vsync_q   <= beat.vsync;
        visible_q <= beat.visible;
      end
    end
  end

  // read data is meaningless in the porches, so blank it
  always_comb begin
    pixel.hsync = hsync_q;
    pixel.vsync = vsync_q;
    pixel.color = visible_q ? rd_color : '0;
  end

endmodule

/* source/pixel_out_fifo.sv */
module pixel_out_fifo (
  input  logic                               clk,
  input  logic                               rst,
  input  gfx_vga_pkg::vga_pixel_t            pixel,
  input  logic                               push,
  output logic                               almost_full,
  output logic [gfx_vga_pkg::COLOR_BITS-1:0] vga_red,
  output logic [gfx_vga_pkg::COLOR_BITS-1:0] vga_grn,
  output logic [gfx_vga_pkg::COLOR_BITS-1:0] vga_blu,
  output logic                               vga_hsync,
  output logic                               vga_vsync,
  output logic                               vga_valid
);

  gfx_vga_pkg::vga_pixel_t mem [gfx_vga_pkg::FIFO_DEPTH];

  gfx_vga_pkg::fifo_ptr_t wr_ptr;
  gfx_vga_pkg::fifo_ptr_t rd_ptr;
  gfx_vga_pkg::fifo_cnt_t count;
  gfx_vga_pkg::div_cnt_t  div_cnt;
  gfx_vga_pkg::vga_pixel_t head;

  logic full;
  logic empty;
  logic tick;
  logic pop;

  assign full  = (count == gfx_vga_pkg::fifo_cnt_t'(gfx_vga_pkg::FIFO_DEPTH));
  assign empty = (count == '0);

  // throttle for the raster counters, with room for the pixels in flight
  assign almost_full = (count >= gfx_vga_pkg::fifo_cnt_t'(gfx_vga_pkg::ALMOST_FULL_LEVEL));

  // pixel rate, one tick every PIXEL_DIV cycles
  assign tick = (div_cnt == gfx_vga_pkg::div_cnt_t'(gfx_vga_pkg::PIXEL_DIV - 1));
  assign pop  = tick && !empty;
  assign head = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt <= '0;
    end else if (tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= pixel;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // registered VGA outputs, syncs idle high
  always_ff @(posedge clk) begin
    if (rst) begin
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      vga_red   <= '0;
      vga_grn   <= '0;
      vga_blu   <= '0;
      vga_valid <= 1'b0;
    end else begin
      vga_valid <= pop;
      if (pop) begin
        vga_hsync <= head.hsync;
        vga_vsync <= head.vsync;
        {vga_red, vga_grn, vga_blu} <= head.color;
      end
    end
  end

  // the almost-full margin must cover the beats still in the pipeline
  assert property (@(posedge clk) disable iff (rst)
    push |-> !full);

  // an emitted pixel was stored in the FIFO before it left
  assert property (@(posedge clk) disable iff (rst)
    vga_valid |-> $past(count) != '0);

endmodule

/* source/gfx_vga.sv */
module gfx_vga (
  input  logic                               clk,
  input  logic                               rst,

  // drawing client
  input  logic [gfx_vga_pkg::FB_X_BITS-1:0]  gfx_x,
  input  logic [gfx_vga_pkg::FB_Y_BITS-1:0]  gfx_y,
  input  logic [gfx_vga_pkg::PIXEL_BITS-1:0] gfx_color,
  input  logic                               gfx_valid,
  input  logic                               gfx_clear,
  output logic                               gfx_ready,
  output logic                               gfx_vsync,

  // VGA side
  input  logic                               vga_enable,
  output logic [gfx_vga_pkg::COLOR_BITS-1:0] vga_red,
  output logic [gfx_vga_pkg::COLOR_BITS-1:0] vga_grn,
  output logic [gfx_vga_pkg::COLOR_BITS-1:0] vga_blu,
  output logic                               vga_hsync,
  output logic                               vga_vsync,
  output logic                               vga_valid
);

  gfx_vga_pkg::fb_write_t    fb_write;
  gfx_vga_pkg::fb_addr_t     rd_addr;
  gfx_vga_pkg::pixel_color_t rd_color;
  gfx_vga_pkg::scan_beat_t   beat;
  gfx_vga_pkg::vga_pixel_t   pixel;
  logic                      beat_strobe;
  logic                      push;
  logic                      fifo_almost_full;

  fb_writer fb_writer_inst (
    .clk      (clk),
    .rst      (rst),
    .gfx_x    (gfx_x),
    .gfx_y    (gfx_y),
    .gfx_color(gfx_color),
    .gfx_valid(gfx_valid),
    .gfx_clear(gfx_clear),
    .gfx_ready(gfx_ready),
    .fb_write (fb_write)
  );

  fb_memory fb_memory_inst (
    .clk     (clk),
    .fb_write(fb_write),
    .rd_addr (rd_addr),
    .rd_color(rd_color)
  );

  vga_timing vga_timing_inst (
    .clk             (clk),
    .rst             (rst),
    .vga_enable      (vga_enable),
    .fifo_almost_full(fifo_almost_full),
    .beat            (beat),
    .beat_strobe     (beat_strobe),
    .gfx_vsync       (gfx_vsync)
  );

  pixel_fetch pixel_fetch_inst (
    .clk        (clk),
    .rst        (rst),
    .beat       (beat),
    .beat_strobe(beat_strobe),
    .rd_addr    (rd_addr),
    .rd_color   (rd_color),
    .pixel      (pixel),
    .push       (push)
  );

  pixel_out_fifo pixel_out_fifo_inst (
    .clk        (clk),
    .rst        (rst),
    .pixel      (pixel),
    .push       (push),
    .almost_full(fifo_almost_full),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync),
    .vga_valid  (vga_valid)
  );

endmodule

/* testbench/gfx_vga_tb.sv */
module gfx_vga_tb;

  localparam int FRAME_BEATS = gfx_vga_pkg::H_WHOLE_LINE * gfx_vga_pkg::V_WHOLE_FRAME;
  // about 2000 cycles of scans, writes, clears and drains, three times over
  localparam int TIMEOUT_CYCLES = 6000;
  localparam logic [31:0] RANDOM_SEED = 32'haa75d63d;
  // longer than any gap between two pixels while something is still in flight
  localparam int QUIET_CYCLES = 2 * gfx_vga_pkg::PIXEL_DIV + 2;

  // raster index of the first beat of the vsync line
  localparam int VSYNC_FALL_POS =
    (gfx_vga_pkg::V_VISIBLE + gfx_vga_pkg::V_FRONT_PORCH) * gfx_vga_pkg::H_WHOLE_LINE;

  typedef logic [gfx_vga_pkg::FB_X_BITS-1:0] coord_x_t;
  typedef logic [gfx_vga_pkg::FB_Y_BITS-1:0] coord_y_t;

  logic                                clk;
  logic                                rst;
  coord_x_t                            gfx_x;
  coord_y_t                            gfx_y;
  gfx_vga_pkg::pixel_color_t           gfx_color;
  logic                                gfx_valid;
  logic                                gfx_clear;
  logic                                vga_enable;
  logic                                gfx_ready;
  logic                                gfx_vsync;
  logic [gfx_vga_pkg::COLOR_BITS-1:0]  vga_red;
  logic [gfx_vga_pkg::COLOR_BITS-1:0]  vga_grn;
  logic [gfx_vga_pkg::COLOR_BITS-1:0]  vga_blu;
  logic                                vga_hsync;
  logic                                vga_vsync;
  logic                                vga_valid;

  // expected frame buffer contents
  gfx_vga_pkg::pixel_color_t shadow [gfx_vga_pkg::FB_PIXELS];

  gfx_vga_pkg::vga_pixel_t seen_q [$];
  int                      stamp_q [$];

  int   cycle = 0;
  int   errors = 0;
  int   checks = 0;
  int   scan_pos = 0;
  int   vsync_falls = 0;
  logic prev_gfx_vsync = 1'b1;

  gfx_vga UUT (
    .clk       (clk),
    .rst       (rst),
    .gfx_x     (gfx_x),
    .gfx_y     (gfx_y),
    .gfx_color (gfx_color),
    .gfx_valid (gfx_valid),
    .gfx_clear (gfx_clear),
    .gfx_ready (gfx_ready),
    .gfx_vsync (gfx_vsync),
    .vga_enable(vga_enable),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .vga_valid (vga_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run was still going after %0d cycles", TIMEOUT_CYCLES);
      $display("Checks run: %0d, errors: %0d", checks, errors);
      $display("Errors found");
      $finish;
    end
  end

  // sample mid-cycle, away from the edge where outputs change
  always @(negedge clk) begin : monitor
    gfx_vga_pkg::vga_pixel_t px;
    if (!rst) begin
      if (vga_valid) begin
        px.hsync = vga_hsync;
        px.vsync = vga_vsync;
        px.color = {vga_red, vga_grn, vga_blu};
        seen_q.push_back(px);
        stamp_q.push_back(cycle);
      end
      if (prev_gfx_vsync && !gfx_vsync) begin
        vsync_falls++;
      end
      prev_gfx_vsync = gfx_vsync;
    end
  end

  // pixel expected at a raster index counted from the first beat after reset
  function automatic gfx_vga_pkg::vga_pixel_t expected_pixel(input int pos);
    int                      x;
    int                      y;
    int                      h_lo;
    int                      v_lo;
    gfx_vga_pkg::vga_pixel_t px;
    x = pos % gfx_vga_pkg::H_WHOLE_LINE;
    y = (pos / gfx_vga_pkg::H_WHOLE_LINE) % gfx_vga_pkg::V_WHOLE_FRAME;
    h_lo = gfx_vga_pkg::H_VISIBLE + gfx_vga_pkg::H_FRONT_PORCH;
    v_lo = gfx_vga_pkg::V_VISIBLE + gfx_vga_pkg::V_FRONT_PORCH;
    // sync pulses sit right after the front porch, active low
    px.hsync = !(x >= h_lo && x < h_lo + gfx_vga_pkg::H_SYNC_PULSE);
    px.vsync = !(y >= v_lo && y < v_lo + gfx_vga_pkg::V_SYNC_PULSE);
    if (x < gfx_vga_pkg::H_VISIBLE && y < gfx_vga_pkg::V_VISIBLE) begin
      px.color = shadow[y * gfx_vga_pkg::H_VISIBLE + x];
    end else begin
      px.color = '0;
    end
    return px;
  endfunction

  task automatic check_value(input string test, input string what,
                             input int expected, input int actual);
    checks++;
    assert (expected == actual) else begin
      errors++;
      $display("MISMATCH %s %s: expected %0d, actual %0d", test, what, expected, actual);
    end
  endtask

  task automatic check_true(input string test, input bit ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("%s: %s", test, what);
    end
  endtask

  // one client pixel, held until the handshake edge
  task automatic write_pixel(input int x, input int y, input gfx_vga_pkg::pixel_color_t color);
    gfx_x     = coord_x_t'(x);
    gfx_y     = coord_y_t'(y);
    gfx_color = color;
    gfx_valid = 1'b1;
    while (!gfx_ready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    gfx_valid = 1'b0;
    if (x < gfx_vga_pkg::H_VISIBLE && y < gfx_vga_pkg::V_VISIBLE) begin
      shadow[y * gfx_vga_pkg::H_VISIBLE + x] = color;
    end
  endtask

  task automatic wait_drained();
    int quiet;
    quiet = 0;
    while (quiet < QUIET_CYCLES) begin
      @(posedge clk);
      #1;
      if (vga_valid) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
  endtask

  // scan until enough pixels came out, then stop and let the pipeline empty
  task automatic run_scan(input int beats);
    stamp_q.delete();
    vsync_falls = 0;
    vga_enable  = 1'b1;
    while (seen_q.size() < beats) begin
      @(posedge clk);
    end
    #1;
    vga_enable = 1'b0;
    wait_drained();
  endtask

  task automatic check_scan(input string test);
    gfx_vga_pkg::vga_pixel_t got;
    gfx_vga_pkg::vga_pixel_t exp;
    while (seen_q.size() > 0) begin
      got = seen_q.pop_front();
      exp = expected_pixel(scan_pos);
      checks++;
      assert (got == exp) else begin
        errors++;
        $display("MISMATCH %s raster %0d: expected hs %b vs %b color %h, actual hs %b vs %b color %h",
                 test, scan_pos % FRAME_BEATS, exp.hsync, exp.vsync, exp.color,
                 got.hsync, got.vsync, got.color);
      end
      scan_pos++;
    end
  endtask

  task automatic test_reset_clear();
    int wait_cycles;
    check_value("test_reset_clear", "gfx_ready", 0, int'(gfx_ready));
    check_value("test_reset_clear", "vga_valid", 0, int'(vga_valid));
    check_value("test_reset_clear", "vga_hsync", 1, int'(vga_hsync));
    check_value("test_reset_clear", "vga_vsync", 1, int'(vga_vsync));
    check_value("test_reset_clear", "color", 0, int'({vga_red, vga_grn, vga_blu}));
    wait_cycles = 0;
    while (!gfx_ready && wait_cycles < gfx_vga_pkg::FB_PIXELS + 2) begin
      @(posedge clk);
      #1;
      wait_cycles++;
    end
    check_true("test_reset_clear", gfx_ready == 1'b1,
               "gfx_ready did not rise after the power-on clear");
    check_true("test_reset_clear", seen_q.size() == 0,
               "vga_valid pulsed while the scan was disabled");
    run_scan(FRAME_BEATS);
    check_scan("test_reset_clear");
  endtask

  task automatic test_frame_readout();
    int x;
    int y;
    for (y = 0; y < gfx_vga_pkg::V_VISIBLE; y++) begin
      for (x = 0; x < gfx_vga_pkg::H_VISIBLE; x++) begin
        write_pixel(x, y, gfx_vga_pkg::pixel_color_t'($urandom));
      end
    end
    run_scan(2 * FRAME_BEATS);
    check_scan("test_frame_readout");
  endtask

  task automatic test_clip();
    int xs [5];
    int ys [5];
    int i;
    xs = '{8, 15, 0, 7, 12};
    ys = '{0, 3, 4, 7, 6};
    for (i = 0; i < 5; i++) begin
      check_true("test_clip", gfx_ready == 1'b1, "writer not ready for an off-screen pixel");
      write_pixel(xs[i], ys[i], gfx_vga_pkg::pixel_color_t'($urandom));
    end
    run_scan(FRAME_BEATS);
    check_scan("test_clip");
  endtask

  task automatic test_rate_and_vsync();
    int expected_falls;
    int pos;
    int i;
    run_scan(2 * FRAME_BEATS);
    for (i = 1; i < stamp_q.size(); i++) begin
      check_value("test_rate_and_vsync", "vga_valid spacing", gfx_vga_pkg::PIXEL_DIV,
                  stamp_q[i] - stamp_q[i-1]);
    end
    expected_falls = 0;
    for (pos = scan_pos; pos < scan_pos + seen_q.size(); pos++) begin
      if (pos % FRAME_BEATS == VSYNC_FALL_POS) begin
        expected_falls++;
      end
    end
    check_value("test_rate_and_vsync", "gfx_vsync falls", expected_falls, vsync_falls);
    check_scan("test_rate_and_vsync");
  endtask

  task automatic test_enable_pause();
    int held;
    vga_enable = 1'b1;
    while (seen_q.size() < 30) begin
      @(posedge clk);
    end
    #1;
    vga_enable = 1'b0;
    repeat (30) @(posedge clk);
    held = seen_q.size();
    repeat (10) @(posedge clk);
    #1;
    check_true("test_enable_pause", seen_q.size() == held && !vga_valid,
               "vga_valid still active long after vga_enable fell");
    run_scan(30 + FRAME_BEATS);
    check_scan("test_enable_pause");
  endtask

  task automatic test_gfx_clear();
    int low_cycles;
    int i;
    check_true("test_gfx_clear", gfx_ready == 1'b1, "writer busy before the clear request");
    gfx_clear = 1'b1;
    @(posedge clk);
    #1;
    gfx_clear = 1'b0;
    low_cycles = 0;
    while (!gfx_ready && low_cycles <= gfx_vga_pkg::FB_PIXELS + 2) begin
      low_cycles++;
      @(posedge clk);
      #1;
    end
    check_value("test_gfx_clear", "gfx_ready low cycles", gfx_vga_pkg::FB_PIXELS, low_cycles);
    for (i = 0; i < gfx_vga_pkg::FB_PIXELS; i++) begin
      shadow[i] = '0;
    end
    run_scan(FRAME_BEATS);
    check_scan("test_gfx_clear");
  endtask

  initial begin : main
    int i;
    rst        = 1'b1;
    gfx_x      = '0;
    gfx_y      = '0;
    gfx_color  = '0;
    gfx_valid  = 1'b0;
    gfx_clear  = 1'b0;
    vga_enable = 1'b0;
    void'($urandom(RANDOM_SEED));
    for (i = 0; i < gfx_vga_pkg::FB_PIXELS; i++) begin
      shadow[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    test_reset_clear();
    test_frame_readout();
    test_clip();
    test_rate_and_vsync();
    test_enable_pause();
    test_gfx_clear();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* gfx_vga.f */
source/gfx_vga_pkg.sv
source/fb_writer.sv
source/fb_memory.sv
source/vga_timing.sv
source/pixel_fetch.sv
source/pixel_out_fifo.sv
source/gfx_vga.sv
testbench/gfx_vga_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the gfx_vga testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module gfx_vga_tb \
  -f gfx_vga.f -o sim_gfx_vga > build.log 2>&1
status=$?
cat build.log
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/sim_gfx_vga > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" sim.log; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
exit 0
